// File: rtl/bus_pkg.sv
// register map and geometry of the host register bus
// one pwm channel owns regs_per_unit consecutive word addresses
// the window of unit n starts at pwm_base + n * regs_per_unit
// the status register is read only and writes to it are ignored
`default_nettype none

package bus_pkg;

   localparam int addr_w = 8;
   localparam int data_w = 32;

   // channel windows
   localparam int pwm_base      = 16;
   localparam int regs_per_unit = 5;

   // register offsets inside one window
   localparam logic [addr_w-1:0] reg_period  = 8'd0;
   localparam logic [addr_w-1:0] reg_on_time = 8'd1;
   localparam logic [addr_w-1:0] reg_config  = 8'd2;
   localparam logic [addr_w-1:0] reg_status  = 8'd3;   // read only
   localparam logic [addr_w-1:0] reg_hbridge = 8'd4;

   // slave handshake states
   localparam logic [1:0] bus_idle    = 2'd0;
   localparam logic [1:0] bus_strobe  = 2'd1;   // one cycle of read or write strobe
   localparam logic [1:0] bus_ack     = 2'd2;
   localparam logic [1:0] bus_release = 2'd3;

endpackage

`default_nettype wire

// File: rtl/pwm_pkg.sv
// pwm and h-bridge encodings shared by the channel blocks
// the adjustments match the counter scheme in pwm_gen
// times must satisfy on >= 2 and period >= on + 2 cycles
`default_nettype none

package pwm_pkg;

   // config register
   localparam int cfg_enable = 0;

   // subtracted from written times so widths come out in whole cycles
   localparam logic [31:0] period_adjust = 32'd1;
   localparam logic [31:0] on_adjust     = 32'd1;

   // h-bridge config register fields
   localparam int hb_enable_bit = 0;
   localparam int hb_mode_bit   = 1;   // 0 pwm, 1 direct
   localparam int hb_cmd_lsb    = 2;   // 2-bit command in bits 3:2
   localparam int hb_dwell_bit  = 4;   // brake or coast while pwm is low

   localparam logic [1:0] hb_coast   = 2'd0;
   localparam logic [1:0] hb_forward = 2'd1;
   localparam logic [1:0] hb_reverse = 2'd2;
   localparam logic [1:0] hb_brake   = 2'd3;

   // both legs low for this many cycles on a direction reversal
   localparam int dead_cycles = 4;
   localparam int dead_cnt_w  = $clog2(dead_cycles + 1);

   // pulse generator states
   localparam logic [1:0] gen_off  = 2'd0;
   localparam logic [1:0] gen_load = 2'd1;
   localparam logic [1:0] gen_high = 2'd2;
   localparam logic [1:0] gen_low  = 2'd3;

endpackage

`default_nettype wire

// File: rtl/bus_fsm.sv
// bus slave for the two-wire handshake
// the host holds rw and the address stable until handshake_2 is high
// exactly one read or write strobe is issued per transfer
// handshake_2 never rises for an address outside the window
`timescale 1ns/1ps
`default_nettype none

module bus_fsm (
   input  logic clk,
   input  logic reset,
   input  logic handshake_1,
   input  logic rw,
   input  logic select,
   output logic handshake_2,
   output logic write_strobe,
   output logic read_strobe
);

   import bus_pkg::*;

   logic [1:0] state;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state       <= bus_idle;
         handshake_2 <= 1'b0;
      end else begin
         // ack goes up one edge after the strobe cycle and drops as soon as host lets go
         handshake_2 <= (state == bus_ack) && handshake_1;
         case (state)
            bus_idle: begin
               if (handshake_1 && select) begin
                  state <= bus_strobe;
               end
            end
            bus_strobe: begin
               state <= bus_ack;
            end
            bus_ack: begin
               if (!handshake_1) begin   // slow host just keeps us here
                  state <= bus_release;
               end
            end
            default: begin
               state <= bus_idle;   // one spare cycle before the next decode
            end
         endcase
      end
   end

   assign write_strobe = (state == bus_strobe) && rw;    // rw high is a host write
   assign read_strobe  = (state == bus_strobe) && !rw;

   // ack only rises for a selected host request taken three edges earlier
   hs2_after_hs1: assert property (
      @(posedge clk) disable iff (!reset)
      $rose(handshake_2) |-> $past(handshake_1 && select, 3)
   ) else $error("handshake_2 rose without a selected request on handshake_1");

endmodule

`default_nettype wire

// File: rtl/pwm_regs.sv
// register file of one pwm channel
// the window sits at pwm_base + unit * regs_per_unit
// period and on-time are stored minus their adjustments and read back that way
// writing either time clears the enable bit in config
// read data is captured on read_strobe and is zero while the address is outside
`timescale 1ns/1ps
`default_nettype none

module pwm_regs #(
   parameter int unit = 0
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [bus_pkg::addr_w-1:0] reg_address,
   input  logic [bus_pkg::data_w-1:0] data_out,
   input  logic                       write_strobe,
   input  logic                       read_strobe,
   input  logic                       pwm,
   output logic                       select,
   output logic [bus_pkg::data_w-1:0] data_in,
   output logic [bus_pkg::data_w-1:0] period_time,
   output logic [bus_pkg::data_w-1:0] on_time,
   output logic                       enable,
   output logic [4:0]                 hb_config
);

   import bus_pkg::*;
   import pwm_pkg::*;

   localparam logic [addr_w-1:0] win_base = addr_w'(pwm_base + unit * regs_per_unit);

   logic [addr_w-1:0] offset;
   logic [data_w-1:0] pwm_config;
   logic [data_w-1:0] status_word;
   logic [data_w-1:0] rdata;

   // address decode
   assign offset = reg_address - win_base;
   assign select = (reg_address >= win_base) && (offset < addr_w'(regs_per_unit));

   assign status_word = {pwm, {(data_w - 17){1'b0}}, pwm_config[15:0]};
   assign enable      = pwm_config[cfg_enable];
   assign data_in     = select ? rdata : '0;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         pwm_config <= '0;
         hb_config  <= '0;
      end else if (write_strobe) begin
         case (offset)
            reg_period, reg_on_time: pwm_config[cfg_enable] <= 1'b0;   // stop on new times
            reg_config:              pwm_config <= data_out;
            reg_hbridge:             hb_config  <= data_out[4:0];
            default:                 ;
         endcase
      end
   end

   // times as the generator counts them
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_time <= '0;
         on_time     <= '0;
      end else begin
         if (write_strobe && (offset == reg_period)) begin
            period_time <= data_out - period_adjust;
         end
         if (write_strobe && (offset == reg_on_time)) begin
            on_time <= data_out - on_adjust;
         end
      end
   end

   // read word, held until the next read
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         rdata <= '0;
      end else if (read_strobe) begin
         case (offset)
            reg_period:  rdata <= period_time;
            reg_on_time: rdata <= on_time;
            reg_config:  rdata <= pwm_config;
            reg_status:  rdata <= status_word;    // live pwm level in bit 31
            reg_hbridge: rdata <= {{(data_w - 5){1'b0}}, hb_config};
            default:     rdata <= '0;
         endcase
      end
   end

   // strobes from the bus slave only arrive for our own window
   strobe_in_window: assert property (
      @(posedge clk) disable iff (!reset)
      (write_strobe || read_strobe) |-> select
   ) else $error("bus strobe for an address outside the channel window");

endmodule

`default_nettype wire

// File: rtl/pwm_gen.sv
// pulse generator with period and on-time down counters
// inputs are the adjusted times from the register file
// pwm rises one edge after enable is seen high
// needs on >= 2 and period >= on + 2 in written cycles
`timescale 1ns/1ps
`default_nettype none

module pwm_gen (
   input  logic        clk,
   input  logic        reset,
   input  logic        enable,
   input  logic [31:0] period_time,
   input  logic [31:0] on_time,
   output logic        pwm
);

   import pwm_pkg::*;

   logic [1:0]  state;
   logic [31:0] on_cnt;    // cycles left high
   logic [31:0] per_cnt;   // cycles left in the period

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state   <= gen_off;
         on_cnt  <= '0;
         per_cnt <= '0;
      end else if (!enable) begin
         state <= gen_off;
      end else begin
         case (state)
            gen_off: begin
               state <= gen_load;
            end
            gen_load: begin
               on_cnt  <= on_time;
               per_cnt <= period_time;
               state   <= gen_high;
            end
            gen_high: begin
               per_cnt <= per_cnt - 1'b1;   // period runs through the high phase too
               if (on_cnt == '0) begin
                  state <= gen_low;
               end else begin
                  on_cnt <= on_cnt - 1'b1;
               end
            end
            default: begin
               // end of period reloads both counters and goes straight back high
               if (per_cnt == '0) begin
                  on_cnt  <= on_time;
                  per_cnt <= period_time;
                  state   <= gen_high;
               end else begin
                  per_cnt <= per_cnt - 1'b1;
               end
            end
         endcase
      end
   end

   assign pwm = (state == gen_high);

   pwm_off_after_disable: assert property (
      @(posedge clk) disable iff (!reset)
      !enable |=> !pwm
   ) else $error("pwm still high one cycle after enable went low");

endmodule

`default_nettype wire

// File: rtl/h_bridge.sv
// h-bridge leg driver with registered outputs
// pwm mode gates the commanded leg with pwm, direct mode drives it statically
// a forward/reverse change forces both legs low for dead_cycles first
// brake drives both legs high
`timescale 1ns/1ps
`default_nettype none

module h_bridge (
   input  logic       clk,
   input  logic       reset,
   input  logic       pwm,
   input  logic [4:0] hb_config,
   output logic       h_bridge_1,
   output logic       h_bridge_2
);

   import pwm_pkg::*;

   logic                  hb_en;
   logic                  hb_mode;
   logic                  hb_dwell;
   logic [1:0]            cmd;
   logic [1:0]            last_dir;   // last forward or reverse command
   logic [1:0]            legs;       // {leg 1, leg 2}
   logic                  reversal;
   logic [dead_cnt_w-1:0] dead_cnt;

   assign hb_en    = hb_config[hb_enable_bit];
   assign hb_mode  = hb_config[hb_mode_bit];
   assign hb_dwell = hb_config[hb_dwell_bit];
   assign cmd      = hb_config[hb_cmd_lsb +: 2];

   always_comb begin
      legs = 2'b00;
      if (hb_en) begin
         case (cmd)
            hb_forward: legs = (pwm || hb_mode) ? 2'b10 : {2{hb_dwell}};
            hb_reverse: legs = (pwm || hb_mode) ? 2'b01 : {2{hb_dwell}};
            hb_brake:   legs = 2'b11;
            default:    legs = 2'b00;
         endcase
      end
   end

   assign reversal = ((cmd == hb_forward) && (last_dir == hb_reverse)) ||
                     ((cmd == hb_reverse) && (last_dir == hb_forward));

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         last_dir   <= hb_coast;
         dead_cnt   <= '0;
         h_bridge_1 <= 1'b0;
         h_bridge_2 <= 1'b0;
      end else begin
         if ((cmd == hb_forward) || (cmd == hb_reverse)) begin
            last_dir <= cmd;
         end
         if (reversal) begin
            dead_cnt                 <= dead_cnt_w'(dead_cycles - 1);   // this cycle counts
            {h_bridge_1, h_bridge_2} <= 2'b00;
         end else if (dead_cnt != '0) begin
            dead_cnt                 <= dead_cnt - 1'b1;
            {h_bridge_1, h_bridge_2} <= 2'b00;
         end else begin
            {h_bridge_1, h_bridge_2} <= legs;
         end
      end
   end

   // no direct swap from one single leg to the other
   no_swap_1_to_2: assert property (
      @(posedge clk) disable iff (!reset)
      (h_bridge_1 && !h_bridge_2) |=> !(h_bridge_2 && !h_bridge_1)
   ) else $error("leg 2 driven right after leg 1 alone");

   no_swap_2_to_1: assert property (
      @(posedge clk) disable iff (!reset)
      (h_bridge_2 && !h_bridge_1) |=> !(h_bridge_1 && !h_bridge_2)
   ) else $error("leg 1 driven right after leg 2 alone");

endmodule

`default_nettype wire

// File: rtl/pwm_subsystem.sv
// one pwm channel behind the host register bus
// unit moves the register window, see bus_pkg
// data_in reads zero when the address is outside the window
`timescale 1ns/1ps
`default_nettype none

module pwm_subsystem #(
   parameter int unit = 0
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       handshake_1,
   input  logic                       rw,
   input  logic [bus_pkg::addr_w-1:0] reg_address,
   input  logic [bus_pkg::data_w-1:0] data_out,
   output logic                       handshake_2,
   output logic [bus_pkg::data_w-1:0] data_in,
   output logic                       pwm_signal,
   output logic                       h_bridge_1,
   output logic                       h_bridge_2
);

   import bus_pkg::*;

   logic              write_strobe;
   logic              read_strobe;
   logic              select;
   logic [data_w-1:0] period_time;
   logic [data_w-1:0] on_time;
   logic              enable;
   logic [4:0]        hb_config;

   bus_fsm i_bus_fsm (
      .clk          (clk),
      .reset        (reset),
      .handshake_1  (handshake_1),
      .rw           (rw),
      .select       (select),
      .handshake_2  (handshake_2),
      .write_strobe (write_strobe),
      .read_strobe  (read_strobe)
   );

   pwm_regs #(.unit(unit)) i_pwm_regs (
      .clk          (clk),
      .reset        (reset),
      .reg_address  (reg_address),
      .data_out     (data_out),
      .write_strobe (write_strobe),
      .read_strobe  (read_strobe),
      .pwm          (pwm_signal),
      .select       (select),
      .data_in      (data_in),
      .period_time  (period_time),
      .on_time      (on_time),
      .enable       (enable),
      .hb_config    (hb_config)
   );

   pwm_gen i_pwm_gen (
      .clk         (clk),
      .reset       (reset),
      .enable      (enable),
      .period_time (period_time),
      .on_time     (on_time),
      .pwm         (pwm_signal)
   );

   h_bridge i_h_bridge (
      .clk        (clk),
      .reset      (reset),
      .pwm        (pwm_signal),
      .hb_config  (hb_config),
      .h_bridge_1 (h_bridge_1),
      .h_bridge_2 (h_bridge_2)
   );

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
// clock and reset source for the testbench
// reset is pulsed high at time 0 so the asynchronous reset sees a falling edge
// reset then stays low for reset_cycles rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int half_period  = 50,
   parameter int reset_cycles = 4
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      #1 reset = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #10 reset = 1'b1;   // release away from the edge
   end

endmodule

`default_nettype wire

// File: verif/tb_pwm_subsystem.sv
// testbench for one pwm channel at unit 0
// inputs change drive_delay ns after the rising edge, outputs are read there too
// times are drawn so that on >= 2 and period >= on + 2 always hold
// the run stops at the first failed check
`timescale 1ns/1ps
`default_nettype none

module tb_pwm_subsystem;

   import bus_pkg::*;
   import pwm_pkg::*;

   localparam int drive_delay = 10;
   localparam int rounds      = 3;          // pulse measurement rounds
   localparam int hb_steps    = 10;
   localparam int xfer_budget = 64 * 12;    // transfers times worst-case cycles each
   localparam logic [addr_w-1:0] win = addr_w'(pwm_base);   // unit 0

   logic              clk;
   logic              reset;
   logic              handshake_1;
   logic              rw;
   logic [addr_w-1:0] reg_address;
   logic [data_w-1:0] data_out;
   logic              handshake_2;
   logic [data_w-1:0] data_in;
   logic              pwm_signal;
   logic              h_bridge_1;
   logic              h_bridge_2;

   logic [31:0] rand_state = 32'h1c5b77c9;
   logic [31:0] cfg_model  = '0;   // expected config register
   logic [4:0]  hb_model   = '0;
   logic [1:0]  pwm_hist   = '0;   // pwm before the last two rising edges
   logic [1:0]  last_single = '0;  // last leg that was driven alone
   logic        pwm_at_read;
   int          low_run     = 0;
   int          reversals   = 0;
   int          cycle_count = 0;
   int          cycle_limit = 1000000;
   int          on_list[rounds+1];
   int          per_list[rounds+1];

   tb_clock #(.half_period(50), .reset_cycles(4)) i_tb_clock (
      .clk   (clk),
      .reset (reset)
   );

   pwm_subsystem #(.unit(0)) i_pwm_subsystem (
      .clk         (clk),
      .reset       (reset),
      .handshake_1 (handshake_1),
      .rw          (rw),
      .reg_address (reg_address),
      .data_out    (data_out),
      .handshake_2 (handshake_2),
      .data_in     (data_in),
      .pwm_signal  (pwm_signal),
      .h_bridge_1  (h_bridge_1),
      .h_bridge_2  (h_bridge_2)
   );

   task automatic abort_run();
      $display("STATUS: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
   endtask

   task automatic flag_problem(input string what);
      $display("error at %0t ns: %s", $time, what);
      abort_run();
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int rand_between(input int lo, input int hi);
      rand_state = xorshift(rand_state);
      return lo + int'(rand_state % 32'(hi - lo + 1));
   endfunction

   // h-bridge config word from its fields
   function automatic logic [4:0] hb_word(input logic en, input logic direct,
                                          input logic [1:0] cmd, input logic dwell);
      logic [4:0] w;
      w = '0;
      w[hb_enable_bit]   = en;
      w[hb_mode_bit]     = direct;
      w[hb_cmd_lsb +: 2] = cmd;
      w[hb_dwell_bit]    = dwell;
      return w;
   endfunction

   // {leg 1, leg 2} for a config and the pwm level one edge earlier
   function automatic logic [1:0] expected_legs(input logic [4:0] cfg, input logic level);
      logic [1:0] cmd;
      cmd = cfg[hb_cmd_lsb +: 2];
      if (!cfg[hb_enable_bit] || cmd == hb_coast) return 2'b00;
      if (cmd == hb_brake) return 2'b11;
      if (!cfg[hb_mode_bit] && !level) return {2{cfg[hb_dwell_bit]}};
      return (cmd == hb_forward) ? 2'b10 : 2'b01;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #drive_delay;
   endtask

   task automatic run_handshake(input logic write, input logic [addr_w-1:0] offset,
                                input logic [data_w-1:0] data, output logic [data_w-1:0] rd);
      int waited;
      waited = 0;
      next_cycle();
      rw          = write;
      reg_address = win + offset;
      data_out    = data;
      handshake_1 = 1'b1;
      while (!handshake_2) begin
         next_cycle();
         waited++;
         if (waited > 8) flag_problem("no handshake_2 for an address inside the window");
      end
      rd          = data_in;
      pwm_at_read = pwm_hist[1];   // level when the read strobe ended
      handshake_1 = 1'b0;
      while (handshake_2) next_cycle();
   endtask

   task automatic bus_write(input logic [addr_w-1:0] offset, input logic [data_w-1:0] data);
      logic [data_w-1:0] unused;
      run_handshake(1'b1, offset, data, unused);
      case (offset)
         reg_period, reg_on_time: cfg_model[cfg_enable] = 1'b0;   // new times stop the channel
         reg_config:              cfg_model = data;
         reg_hbridge:             hb_model = data[4:0];
         default:                 ;
      endcase
   endtask

   task automatic bus_read(input logic [addr_w-1:0] offset, output logic [data_w-1:0] rd);
      run_handshake(1'b0, offset, '0, rd);
   endtask

   task automatic check_config();
      logic [data_w-1:0] rd;
      bus_read(reg_config, rd);
      assert (rd == cfg_model) else flag_mismatch("config readback", cfg_model, rd);
   endtask

   task automatic wait_pwm(input logic level, input int limit);
      int waited;
      waited = 0;
      while (pwm_signal != level) begin
         next_cycle();
         waited++;
         if (waited > limit) flag_problem("pwm_signal did not reach the expected level");
      end
   endtask

   task automatic measure_pulses(input int on_c, input int per_c);
      int          high_w;
      int          total;
      logic [31:0] cfg_word;
      cfg_word = xorshift(rand_state + 32'(on_c));
      bus_write(reg_period, per_c);
      bus_write(reg_on_time, on_c);
      bus_write(reg_config, {cfg_word[31:1], 1'b1});
      wait_pwm(1'b0, on_c + 2);
      wait_pwm(1'b1, per_c + 4);
      repeat (3) begin
         high_w = 0;
         total  = 0;
         while (pwm_signal && total <= 2 * per_c) begin
            next_cycle();
            high_w++;
            total++;
         end
         while (!pwm_signal && total <= 2 * per_c) begin
            next_cycle();
            total++;
         end
         assert (high_w == on_c) else flag_mismatch("pwm high width", on_c, high_w);
         assert (total == per_c) else flag_mismatch("pwm period", per_c, total);
      end
   endtask

   task automatic check_status();
      logic [data_w-1:0] rd;
      bus_read(reg_status, rd);
      assert (rd[31] == pwm_at_read) else flag_mismatch("status bit 31", pwm_at_read, rd[31]);
      assert (rd[15:0] == cfg_model[15:0])
         else flag_mismatch("status bits 15:0", cfg_model[15:0], rd[15:0]);
      assert (rd[30:16] == '0) else flag_mismatch("status bits 30:16", 0, rd[30:16]);
   endtask

   task automatic expect_pwm_low(input int cycles);
      repeat (cycles) begin
         next_cycle();
         assert (!pwm_signal) else flag_mismatch("pwm_signal", 0, pwm_signal);
      end
   endtask

   task automatic check_bridge(input logic [4:0] cfg, input int cycles);
      logic [1:0] exp;
      bus_write(reg_hbridge, {27'd0, cfg});
      repeat (dead_cycles + 2) next_cycle();   // clear of any reversal gap
      repeat (cycles) begin
         next_cycle();
         exp = expected_legs(hb_model, pwm_hist[0]);
         assert ({h_bridge_1, h_bridge_2} == exp)
            else flag_mismatch("h_bridge legs", exp, {h_bridge_1, h_bridge_2});
      end
   endtask

   task automatic probe_outside(input logic [addr_w-1:0] addr, input logic write);
      next_cycle();
      rw          = write;
      reg_address = addr;
      data_out    = 32'hdead_beef;
      handshake_1 = 1'b1;
      repeat (8) begin
         next_cycle();
         assert (!handshake_2) else flag_problem("handshake_2 rose for an address outside");
         assert (data_in == '0) else flag_mismatch("data_in", 0, data_in);
      end
      handshake_1 = 1'b0;
   endtask

   always @(negedge clk) begin
      pwm_hist = {pwm_hist[0], pwm_signal};
      // gap between one leg alone and the other leg alone
      if (h_bridge_1 != h_bridge_2) begin
         if (last_single != 2'b00 && last_single != {h_bridge_1, h_bridge_2}) begin
            reversals++;
            assert (low_run >= dead_cycles) else flag_mismatch("dead cycles", dead_cycles, low_run);
         end
         last_single = {h_bridge_1, h_bridge_2};
         low_run     = 0;
      end else if (!h_bridge_1) begin
         low_run++;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) flag_problem($sformatf("run passed %0d cycles", cycle_limit));
   end

   reset_quiet: assert property (
      @(posedge clk) !reset |-> !handshake_2 && !pwm_signal && !h_bridge_1 && !h_bridge_2
   ) else flag_problem("outputs not low during reset");

   ack_release: assert property (
      @(posedge clk) disable iff (!reset)
      handshake_2 && !handshake_1 |=> !handshake_2
   ) else flag_problem("handshake_2 did not fall one edge after handshake_1 dropped");

   initial begin
      logic [data_w-1:0] w;
      logic [data_w-1:0] rd;
      logic [data_w-1:0] cfg_word;
      int planned;
      handshake_1 = 1'b0;
      rw          = 1'b0;
      reg_address = '0;
      data_out    = '0;
      planned     = 0;
      for (int i = 0; i <= rounds; i++) begin
         on_list[i]  = rand_between(2, 12);
         per_list[i] = rand_between(on_list[i] + 2, on_list[i] + 20);
         planned     += 5 * per_list[i];   // three measured periods plus alignment
      end
      planned += hb_steps * 2 * per_list[rounds] + 2 * (per_list[rounds] + 4);
      cycle_limit = 2 * planned + xfer_budget + 400;
      @(posedge clk);
      wait (reset === 1'b1);

      // register readback with full-width values
      w = xorshift(rand_state ^ 32'h5a5a_0001);
      bus_write(reg_period, w);
      bus_read(reg_period, rd);
      assert (rd == w - period_adjust) else flag_mismatch("period readback", w - period_adjust, rd);
      w = xorshift(w);
      bus_write(reg_on_time, w);
      bus_read(reg_on_time, rd);
      assert (rd == w - on_adjust) else flag_mismatch("on-time readback", w - on_adjust, rd);
      cfg_word = xorshift(w);
      bus_write(reg_config, {cfg_word[31:1], 1'b0});
      check_config();
      bus_write(reg_hbridge, {27'd0, w[4:0]});
      bus_read(reg_hbridge, rd);
      assert (rd == {27'd0, hb_model}) else flag_mismatch("hbridge readback", hb_model, rd);

      for (int i = 0; i < rounds; i++) measure_pulses(on_list[i], per_list[i]);

      // status sampled at random points of a running pulse
      repeat (6) begin
         repeat (rand_between(0, 7)) next_cycle();
         check_status();
      end

      // new times clear the enable bit
      bus_write(reg_period, per_list[rounds]);
      check_config();
      expect_pwm_low(per_list[rounds] + 4);
      bus_write(reg_config, cfg_model | 32'd1);
      bus_write(reg_on_time, on_list[rounds]);
      check_config();
      expect_pwm_low(per_list[rounds] + 4);

      // bridge mapping with the pulse running
      bus_write(reg_config, cfg_model | 32'd1);
      check_bridge(hb_word(1'b0, 1'b0, hb_forward, 1'b1), 2 * per_list[rounds]);
      check_bridge(hb_word(1'b1, 1'b0, hb_forward, 1'b0), 2 * per_list[rounds]);
      check_bridge(hb_word(1'b1, 1'b0, hb_forward, 1'b1), 2 * per_list[rounds]);
      check_bridge(hb_word(1'b1, 1'b0, hb_reverse, 1'b0), 2 * per_list[rounds]);
      check_bridge(hb_word(1'b1, 1'b0, hb_reverse, 1'b1), 2 * per_list[rounds]);
      check_bridge(hb_word(1'b1, 1'b0, hb_brake, 1'b0), 2 * per_list[rounds]);
      check_bridge(hb_word(1'b1, 1'b0, hb_coast, 1'b1), 2 * per_list[rounds]);
      check_bridge(hb_word(1'b1, 1'b1, hb_forward, 1'b0), 2 * per_list[rounds]);
      check_bridge(hb_word(1'b1, 1'b1, hb_reverse, 1'b1), 2 * per_list[rounds]);
      check_bridge(hb_word(1'b1, 1'b1, hb_brake, 1'b0), 2 * per_list[rounds]);

      // addresses on both sides of the window
      probe_outside(win + addr_w'(regs_per_unit), 1'b0);
      probe_outside(win - 8'd1, 1'b1);
      check_config();

      if (reversals > 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         flag_problem("no direction reversal reached the dead-time check");
      end
   end

endmodule

`default_nettype wire

// File: flist.f
rtl/bus_pkg.sv
rtl/pwm_pkg.sv
rtl/bus_fsm.sv
rtl/pwm_regs.sv
rtl/pwm_gen.sv
rtl/h_bridge.sv
rtl/pwm_subsystem.sv
verif/tb_clock.sv
verif/tb_pwm_subsystem.sv

// File: Makefile
TOP = tb_pwm_subsystem
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -Wno-fatal --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f flist.f
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
